// ==== hdl/fetch_pkg.sv ====
// ====================
// shared widths, encodings and packet types of the fetch front end
// RV32 only; addresses and instructions are both 32 bits
// only the major opcodes the classifier accepts are listed
// ====================
package fetch_pkg;

	// widths
	localparam int addr_w = 32;
	localparam int inst_w = 32;
	localparam int resp_w = 2;
	localparam int prot_w = 3;

	// first fetch address after reset
	localparam logic [addr_w-1:0] pc_reset_val = 32'h8000_0000;

	// fetch queue size, must be a power of two
	localparam int queue_depth = 4;
	localparam int queue_ptr_w = $clog2(queue_depth);

	// instruction fetch, unprivileged, secure
	localparam logic [prot_w-1:0] ar_prot_inst = 3'b100;

	// funct fields of the supported alu forms
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt = 7'b0100000;

	// the only system instruction taken
	localparam logic [inst_w-1:0] ebreak_word = 32'h0010_0073;

	// rv major opcodes, bits 6:0
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		cls_lui     = 3'd0,
		cls_alu_imm = 3'd1,
		cls_alu_reg = 3'd2,
		cls_ebreak  = 3'd3,
		cls_illegal = 3'd4
	} inst_class_e;

	typedef enum logic [1:0] {
		fs_idle   = 2'd0,
		fs_wait_r = 2'd1,
		fs_halted = 2'd2
	} fetch_state_e;

	// fetched word with its address and the bus response code
	typedef struct packed {
		logic [addr_w-1:0] pc;
		logic [inst_w-1:0] inst;
		logic [resp_w-1:0] resp;
	} fetch_pkt_t;

	// classified word handed to the next stage
	typedef struct packed {
		logic [addr_w-1:0] pc;
		logic [inst_w-1:0] inst;
		inst_class_e       cls;
	} retire_pkt_t;

	// axi4-lite read address payload
	typedef struct packed {
		logic [addr_w-1:0] araddr;
		logic [prot_w-1:0] arprot;
	} axi_ar_t;

	// axi4-lite read data payload
	typedef struct packed {
		logic [inst_w-1:0] rdata;
		logic [resp_w-1:0] rresp;
	} axi_r_t;

endpackage

// ==== hdl/fetch_unit.sv ====
// ====================
// pc register and axi4-lite read master (ar and r only)
// at most one read outstanding; ar stays stable until arready
// a redirect during a read drops that response, then fetches the target
// once halt_i is seen, no further read is issued
// ====================
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect_i,
	input  logic [addr_w-1:0] redirect_pc_i,
	input  logic              halt_i,
	output logic              arvalid_o,
	output axi_ar_t           ar_o,
	input  logic              arready_i,
	input  logic              rvalid_i,
	input  axi_r_t            r_i,
	output logic              rready_o,
	output logic              push_valid_o,
	output fetch_pkt_t        push_o,
	input  logic              push_ready_i
);

	fetch_state_e state_q;
	fetch_state_e state_d;
	logic [addr_w-1:0] pc_q;
	logic [addr_w-1:0] fetch_next;
	axi_ar_t ar_q;
	logic arvalid_q;
	logic discard_q;
	logic drop;
	logic ar_hs;
	logic r_hs;

	// response goes nowhere: stale, flushed this cycle, or core halting
	assign drop = discard_q | redirect_i | halt_i;

	assign ar_hs = arvalid_q & arready_i;

	// a dropped response never waits on queue room
	assign rready_o = (state_q == fs_wait_r) & (push_ready_i | drop);
	assign r_hs = rvalid_i & rready_o;

	assign arvalid_o = arvalid_q;
	assign ar_o = ar_q;

	// the outstanding read's address is still held in ar_q
	assign push_valid_o = (state_q == fs_wait_r) & rvalid_i & ~drop;
	assign push_o.pc = ar_q.araddr;
	assign push_o.inst = r_i.rdata;
	assign push_o.resp = r_i.rresp;

	// address of the read that follows the current response
	// pc_q already holds the target when discard_q is set
	always_comb begin
		if (redirect_i) begin
			fetch_next = redirect_pc_i;
		end else if (discard_q) begin
			fetch_next = pc_q;
		end else begin
			fetch_next = pc_q + 32'd4;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			fs_idle: begin
				if (ar_hs) begin
					state_d = fs_wait_r;
				end
			end
			fs_wait_r: begin
				// halt is only checked here, so a pending ar is never withdrawn
				if (r_hs) begin
					state_d = halt_i ? fs_halted : fs_idle;
				end
			end
			fs_halted: begin
				// left only through reset
				state_d = fs_halted;
			end
			default: begin
				state_d = fs_halted;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= fs_idle;
			arvalid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// low during reset, up one cycle later
			arvalid_q <= (state_d == fs_idle);
		end
	end

	// pc register follows the redirect at once, ar_q only at the next issue
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= pc_reset_val;
			ar_q.araddr <= pc_reset_val;
			ar_q.arprot <= ar_prot_inst;
		end else begin
			if (redirect_i) begin
				pc_q <= redirect_pc_i;
			end else if (r_hs) begin
				pc_q <= fetch_next;
			end
			if (r_hs) begin
				ar_q.araddr <= fetch_next;
			end
		end
	end

	// marks the presented or outstanding read as stale
	always_ff @(posedge clock) begin
		if (reset) begin
			discard_q <= 1'b0;
		end else if (r_hs) begin
			discard_q <= 1'b0;
		end else if (redirect_i && state_q != fs_halted) begin
			discard_q <= 1'b1;
		end
	end

endmodule

// ==== hdl/fetch_queue.sv ====
// ====================
// four entry fifo of fetched packets
// push visible at the output one cycle later
// flush empties it in one cycle and wins over a push
// ====================
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       flush_i,
	input  logic       push_valid_i,
	input  fetch_pkt_t push_i,
	output logic       push_ready_o,
	output logic       pop_valid_o,
	output fetch_pkt_t pop_o,
	input  logic       pop_ready_i
);

	fetch_pkt_t mem_q [queue_depth];
	logic [queue_ptr_w-1:0] wr_ptr_q;
	logic [queue_ptr_w-1:0] rd_ptr_q;
	logic [queue_ptr_w:0] count_q;
	logic do_push;
	logic do_pop;

	assign push_ready_o = (count_q != queue_depth[queue_ptr_w:0]);
	assign pop_valid_o = (count_q != '0);
	assign pop_o = mem_q[rd_ptr_q];

	// flushed packets are dead, neither side moves
	assign do_push = push_valid_i & push_ready_o & ~flush_i;
	assign do_pop = pop_valid_o & pop_ready_i & ~flush_i;

	// storage, no reset
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= push_i;
		end
	end

	// pointers wrap naturally at depth 4
	always_ff @(posedge clock) begin
		if (reset || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// push and pop together keep the count
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== hdl/inst_classifier.sv ====
// ====================
// sorts fetched words into lui, alu imm, alu reg, ebreak or illegal
// one output register, valid/ready retire port
// a bus error response always gives illegal
// halt_o is sticky and cleared only by reset
// ====================
`timescale 1ns/1ps

module inst_classifier import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        flush_i,
	input  logic        pop_valid_i,
	input  fetch_pkt_t  pop_i,
	output logic        pop_ready_o,
	output logic        retire_valid_o,
	output retire_pkt_t retire_o,
	input  logic        retire_ready_i,
	output logic        halt_o
);

	retire_pkt_t hold_q;
	logic valid_q;
	logic halt_q;
	logic pop_hs;
	logic retire_hs;
	logic hold_ebreak;

	function automatic inst_class_e classify(input fetch_pkt_t pkt);
		opcode_e op;
		logic [2:0] f3;
		logic [6:0] f7;
		inst_class_e cls;
		op = opcode_e'(pkt.inst[6:0]);
		f3 = pkt.inst[14:12];
		f7 = pkt.inst[31:25];
		cls = cls_illegal;
		if (pkt.resp != '0) begin
			cls = cls_illegal;
		end else if (pkt.inst == ebreak_word) begin
			cls = cls_ebreak;
		end else begin
			case (op)
				op_lui: cls = cls_lui;
				op_imm: begin
					// shifts carry funct7 in the upper immediate bits
					if (f3 == f3_sll) begin
						cls = (f7 == f7_base) ? cls_alu_imm : cls_illegal;
					end else if (f3 == f3_srl) begin
						cls = (f7 == f7_base || f7 == f7_alt) ? cls_alu_imm : cls_illegal;
					end else begin
						cls = cls_alu_imm;
					end
				end
				op_reg: begin
					// alt funct7 only for sub and sra, no m extension
					if (f7 == f7_base) begin
						cls = cls_alu_reg;
					end else if (f7 == f7_alt && (f3 == f3_add || f3 == f3_srl)) begin
						cls = cls_alu_reg;
					end
				end
				// ecall, csr and the rest of system are not taken
				default: cls = cls_illegal;
			endcase
		end
		return cls;
	endfunction

	assign hold_ebreak = valid_q & (hold_q.cls == cls_ebreak);
	assign retire_hs = valid_q & retire_ready_i;

	// refill only when empty or emptying; never past an ebreak
	assign pop_ready_o = ~flush_i & ~halt_q & ~hold_ebreak & (~valid_q | retire_ready_i);
	assign pop_hs = pop_valid_i & pop_ready_o;

	assign retire_valid_o = valid_q;
	assign retire_o = hold_q;
	assign halt_o = halt_q;

	// a retire in the redirect cycle still counts
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			halt_q <= 1'b0;
		end else begin
			if (retire_hs && hold_q.cls == cls_ebreak) begin
				halt_q <= 1'b1;
			end
			if (flush_i) begin
				valid_q <= 1'b0;
			end else if (pop_hs) begin
				valid_q <= 1'b1;
			end else if (retire_hs) begin
				valid_q <= 1'b0;
			end
		end
	end

	// payload register
	always_ff @(posedge clock) begin
		if (pop_hs) begin
			hold_q.pc <= pop_i.pc;
			hold_q.inst <= pop_i.inst;
			hold_q.cls <= classify(pop_i);
		end
	end

endmodule

// ==== hdl/fetch_top.sv ====
// ====================
// fetch front end: fetch unit, fetch queue, classifier
// instruction memory sits outside on the axi4-lite read port
// redirect flushes everything but halt
// ====================
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect_i,
	input  logic [addr_w-1:0] redirect_pc_i,
	output logic              arvalid_o,
	output axi_ar_t           ar_o,
	input  logic              arready_i,
	input  logic              rvalid_i,
	input  axi_r_t            r_i,
	output logic              rready_o,
	output logic              retire_valid_o,
	output retire_pkt_t       retire_o,
	input  logic              retire_ready_i,
	output logic              halt_o
);

	// fetch to queue
	logic push_valid;
	fetch_pkt_t push_pkt;
	logic push_ready;

	// queue to classifier
	logic pop_valid;
	fetch_pkt_t pop_pkt;
	logic pop_ready;

	fetch_unit u_fetch_unit (
		.clock         (clock),
		.reset         (reset),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.halt_i        (halt_o),
		.arvalid_o     (arvalid_o),
		.ar_o          (ar_o),
		.arready_i     (arready_i),
		.rvalid_i      (rvalid_i),
		.r_i           (r_i),
		.rready_o      (rready_o),
		.push_valid_o  (push_valid),
		.push_o        (push_pkt),
		.push_ready_i  (push_ready)
	);

	fetch_queue u_fetch_queue (
		.clock        (clock),
		.reset        (reset),
		.flush_i      (redirect_i),
		.push_valid_i (push_valid),
		.push_i       (push_pkt),
		.push_ready_o (push_ready),
		.pop_valid_o  (pop_valid),
		.pop_o        (pop_pkt),
		.pop_ready_i  (pop_ready)
	);

	// halt feeds back to stop fetch
	inst_classifier u_inst_classifier (
		.clock          (clock),
		.reset          (reset),
		.flush_i        (redirect_i),
		.pop_valid_i    (pop_valid),
		.pop_i          (pop_pkt),
		.pop_ready_o    (pop_ready),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o),
		.retire_ready_i (retire_ready_i),
		.halt_o         (halt_o)
	);

endmodule

// ==== bench/fetch_checker.sv ====
// ====================
// watches the ar channel, the retire port and halt
// expected word and class come in from the program table
// all checks sample at the rising edge, skipped during reset
// ====================
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect_i,
	input  logic [addr_w-1:0] redirect_pc_i,
	input  logic              arvalid_i,
	input  axi_ar_t           ar_i,
	input  logic              arready_i,
	input  logic              retire_valid_i,
	input  retire_pkt_t       retire_i,
	input  logic              retire_ready_i,
	input  logic              halt_i,
	input  logic [inst_w-1:0] exp_inst_i,
	input  inst_class_e       exp_cls_i,
	output int                error_count_o,
	output int                retire_count_o
);

	int errors = 0;
	int retires;
	int reads_after_halt;
	logic [addr_w-1:0] exp_ar;
	logic [addr_w-1:0] exp_pc;
	logic [addr_w-1:0] redir_tgt;
	logic ar_redir;
	logic held_valid;
	retire_pkt_t held;
	logic halt_due;
	logic halt_prev;
	logic arvalid_prev;

	assign error_count_o = errors;
	assign retire_count_o = retires;

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
	endtask

	task automatic rule_error(input string what);
		errors++;
		$display("error: %s at %0t", what, $time);
	endtask

	always @(posedge clock) begin
		if (reset) begin
			retires = 0;
			reads_after_halt = 0;
			exp_ar = pc_reset_val;
			exp_pc = pc_reset_val;
			ar_redir = 1'b0;
			held_valid = 1'b0;
			halt_due = 1'b0;
			halt_prev = 1'b0;
			arvalid_prev = 1'b0;
		end else begin
			// address sequence; a stale address may still go out after a redirect
			if (arvalid_i && arready_i) begin
				if (ar_redir && ar_i.araddr == redir_tgt) begin
					ar_redir = 1'b0;
				end else if (ar_i.araddr != exp_ar) begin
					value_error("ar_o.araddr", ar_i.araddr, ar_redir ? redir_tgt : exp_ar);
				end
				exp_ar = ar_i.araddr + 32'd4;
				// instruction, secure, unprivileged access
				if (ar_i.arprot != 3'b100) begin
					value_error("ar_o.arprot", 32'(ar_i.arprot), 32'h4);
				end
				if (halt_i) begin
					reads_after_halt++;
					if (reads_after_halt > 1) begin
						rule_error("more than one read accepted after halt");
					end
				end
			end
			if (arvalid_i && !arvalid_prev && halt_prev) begin
				rule_error("arvalid raised while halted");
			end
			if (redirect_i) begin
				ar_redir = 1'b1;
				redir_tgt = redirect_pc_i;
			end

			// packet held from the last edge must not move
			if (held_valid) begin
				if (!retire_valid_i) begin
					rule_error("retire_valid_o dropped without a handshake");
				end else begin
					if (retire_i.pc != held.pc) begin
						value_error("retire_o.pc", retire_i.pc, held.pc);
					end
					if (retire_i.inst != held.inst) begin
						value_error("retire_o.inst", retire_i.inst, held.inst);
					end
					if (retire_i.cls != held.cls) begin
						value_error("retire_o.cls", 32'(retire_i.cls), 32'(held.cls));
					end
				end
			end
			if (retire_valid_i && halt_i) begin
				rule_error("packet offered after halt");
			end

			// retire before redirect in the same cycle
			if (retire_valid_i && retire_ready_i) begin
				if (retire_i.pc != exp_pc) begin
					value_error("retire_o.pc", retire_i.pc, exp_pc);
				end
				if (retire_i.inst != exp_inst_i) begin
					value_error("retire_o.inst", retire_i.inst, exp_inst_i);
				end
				if (retire_i.cls != exp_cls_i) begin
					value_error("retire_o.cls", 32'(retire_i.cls), 32'(exp_cls_i));
				end
				exp_pc = retire_i.pc + 32'd4;
				retires++;
			end
			if (redirect_i) begin
				exp_pc = redirect_pc_i;
			end

			// halt one cycle after ebreak retires
			if (halt_due && !halt_i) begin
				value_error("halt_o", 32'(halt_i), 32'h1);
			end
			halt_due = retire_valid_i && retire_ready_i && retire_i.cls == cls_ebreak;

			held_valid = retire_valid_i && !retire_ready_i && !redirect_i;
			held = retire_i;
			arvalid_prev = arvalid_i;
			halt_prev = halt_i;
		end
	end

endmodule

// ==== bench/fetch_sva.sv ====
// ====================
// axi read handshake and fetch queue assertions
// bound into fetch_top, queue internals reached through the bind
// assumes a single outstanding read on the memory side
// ====================
`timescale 1ns/1ps

module fetch_sva import fetch_pkg::*; (
	input logic                 clock,
	input logic                 reset,
	input logic                 arvalid_i,
	input axi_ar_t              ar_i,
	input logic                 arready_i,
	input logic                 rvalid_i,
	input logic                 rready_i,
	input logic [queue_ptr_w:0] q_count_i,
	input logic                 q_push_valid_i
);

	logic outstanding_q;
	// assertion failures so far
	int fail_count = 0;

	// one read between ar and r handshakes
	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding_q <= 1'b0;
		end else if (arvalid_i && arready_i) begin
			outstanding_q <= 1'b1;
		end else if (rvalid_i && rready_i) begin
			outstanding_q <= 1'b0;
		end
	end

	// ar held until accepted
	ar_stable: assert property (@(posedge clock) disable iff (reset)
		arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
		else begin
			fail_count++;
			$error("arvalid or ar changed before arready");
		end

	// no second address while a read is open
	one_read: assert property (@(posedge clock) disable iff (reset)
		outstanding_q |-> !arvalid_i)
		else begin
			fail_count++;
			$error("second read issued while one is outstanding");
		end

	// a packet offered to a full queue must hold the r channel
	no_push_full: assert property (@(posedge clock) disable iff (reset)
		q_count_i == queue_depth && q_push_valid_i |-> !(rvalid_i && rready_i))
		else begin
			fail_count++;
			$error("response taken while the queue was full");
		end

endmodule

bind fetch_top fetch_sva u_fetch_sva (
	.clock          (clock),
	.reset          (reset),
	.arvalid_i      (arvalid_o),
	.ar_i           (ar_o),
	.arready_i      (arready_i),
	.rvalid_i       (rvalid_i),
	.rready_i       (rready_o),
	.q_count_i      (u_fetch_queue.count_q),
	.q_push_valid_i (u_fetch_queue.push_valid_i)
);

// ==== bench/fetch_tb.sv ====
// ====================
// fetch front end testbench
// memory model with random ar and r latency, random retire stalls
// three scenarios, each from its own reset since halt is sticky
// unmapped addresses read as an all-ones illegal word
// ====================
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

	localparam int prog_rows = 14;
	localparam int scen_rows = 3;
	localparam logic [inst_w-1:0] illegal_word = 32'hffff_ffff;

	typedef struct packed {
		logic [11:0]       off;
		logic [inst_w-1:0] word;
		inst_class_e       cls;
	} prog_row_t;

	// redirect_after of zero means no redirect
	typedef struct packed {
		logic [7:0]        redirect_after;
		logic [addr_w-1:0] target;
	} scen_row_t;

	// offset from pc_reset_val, word, expected class
	prog_row_t prog [prog_rows] = '{
		'{12'h000, 32'h1234_50b7, cls_lui},
		'{12'h004, 32'h0050_8113, cls_alu_imm},
		'{12'h008, 32'h0020_81b3, cls_alu_reg},
		'{12'h00c, 32'h4021_d213, cls_alu_imm},
		'{12'h010, 32'h4011_82b3, cls_alu_reg},
		'{12'h014, 32'h0220_8333, cls_illegal},
		'{12'h018, 32'h0010_0073, cls_ebreak},
		'{12'h100, 32'hfff0_c313, cls_alu_imm},
		'{12'h104, 32'h4020_9393, cls_illegal},
		'{12'h108, 32'h0020_e3b3, cls_alu_reg},
		'{12'h10c, 32'h0010_0073, cls_ebreak},
		'{12'h200, 32'h0000_0073, cls_illegal},
		'{12'h204, 32'h0010_b413, cls_alu_imm},
		'{12'h208, 32'h0010_0073, cls_ebreak}
	};

	// straight line, redirect mid-stream, redirect into illegal words
	scen_row_t scen [scen_rows] = '{
		'{8'd0, 32'h0},
		'{8'd2, 32'h8000_0100},
		'{8'd4, 32'h8000_0200}
	};

	logic clock;
	logic reset;
	logic redirect_i;
	logic [addr_w-1:0] redirect_pc_i;
	logic arvalid_o;
	axi_ar_t ar_o;
	logic arready_i;
	logic rvalid_i;
	axi_r_t r_i;
	logic rready_o;
	logic retire_valid_o;
	retire_pkt_t retire_o;
	logic retire_ready_i;
	logic halt_o;
	logic [inst_w-1:0] exp_inst;
	inst_class_e exp_cls;
	int chk_errors;
	int sva_errors;
	int retire_count;
	int timeouts;
	int seed;

	// memory model state
	logic ar_hs_s;
	logic r_hs_s;
	logic arv_s;
	logic [addr_w-1:0] ar_addr_s;
	logic [addr_w-1:0] pend_addr;
	logic pend;
	int ar_delay;
	int r_delay;

	function automatic logic [inst_w-1:0] table_word(input logic [addr_w-1:0] addr);
		logic [inst_w-1:0] w;
		w = illegal_word;
		for (int i = 0; i < prog_rows; i++) begin
			if (pc_reset_val + 32'(prog[i].off) == addr) begin
				w = prog[i].word;
			end
		end
		return w;
	endfunction

	function automatic inst_class_e table_cls(input logic [addr_w-1:0] addr);
		inst_class_e c;
		c = cls_illegal;
		for (int i = 0; i < prog_rows; i++) begin
			if (pc_reset_val + 32'(prog[i].off) == addr) begin
				c = prog[i].cls;
			end
		end
		return c;
	endfunction

	always_comb begin
		exp_inst = table_word(retire_o.pc);
		exp_cls = table_cls(retire_o.pc);
	end

	fetch_top u_fetch_top (
		.clock          (clock),
		.reset          (reset),
		.redirect_i     (redirect_i),
		.redirect_pc_i  (redirect_pc_i),
		.arvalid_o      (arvalid_o),
		.ar_o           (ar_o),
		.arready_i      (arready_i),
		.rvalid_i       (rvalid_i),
		.r_i            (r_i),
		.rready_o       (rready_o),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o),
		.retire_ready_i (retire_ready_i),
		.halt_o         (halt_o)
	);

	fetch_checker u_fetch_checker (
		.clock          (clock),
		.reset          (reset),
		.redirect_i     (redirect_i),
		.redirect_pc_i  (redirect_pc_i),
		.arvalid_i      (arvalid_o),
		.ar_i           (ar_o),
		.arready_i      (arready_i),
		.retire_valid_i (retire_valid_o),
		.retire_i       (retire_o),
		.retire_ready_i (retire_ready_i),
		.halt_i         (halt_o),
		.exp_inst_i     (exp_inst),
		.exp_cls_i      (exp_cls),
		.error_count_o  (chk_errors),
		.retire_count_o (retire_count)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// memory and next stage: sample at the edge, answer 1 ns later
	initial begin
		seed = 36;
		void'($urandom(seed));
		forever begin
			@(posedge clock);
			ar_hs_s = arvalid_o & arready_i;
			r_hs_s = rvalid_i & rready_o;
			arv_s = arvalid_o;
			ar_addr_s = ar_o.araddr;
			#1;
			if (reset) begin
				arready_i = 1'b0;
				rvalid_i = 1'b0;
				r_i = '0;
				pend = 1'b0;
				ar_delay = $urandom % 4;
			end else begin
				if (r_hs_s) begin
					rvalid_i = 1'b0;
					pend = 1'b0;
				end
				if (ar_hs_s) begin
					arready_i = 1'b0;
					pend = 1'b1;
					pend_addr = ar_addr_s;
					r_delay = $urandom % 4;
				end else if (arv_s && !arready_i && !pend) begin
					if (ar_delay == 0) begin
						arready_i = 1'b1;
						ar_delay = $urandom % 4;
					end else begin
						ar_delay--;
					end
				end
				if (pend && !rvalid_i) begin
					if (r_delay == 0) begin
						rvalid_i = 1'b1;
						r_i.rdata = table_word(pend_addr);
						r_i.rresp = '0;
					end else begin
						r_delay--;
					end
				end
			end
			// next stage stalls about one cycle in four
			retire_ready_i = reset ? 1'b0 : ($urandom % 4 != 0);
		end
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic wait_retires(input int n);
		int cyc;
		cyc = 0;
		while (retire_count < n && cyc < 200) begin
			@(posedge clock);
			#1;
			cyc++;
		end
		if (retire_count < n) begin
			timeouts++;
			$display("timeout: only %0d of %0d packets retired", retire_count, n);
		end
	endtask

	task automatic pulse_redirect(input logic [addr_w-1:0] target);
		redirect_i = 1'b1;
		redirect_pc_i = target;
		@(posedge clock);
		#1;
		redirect_i = 1'b0;
	endtask

	task automatic wait_halt(input int s);
		int cyc;
		cyc = 0;
		while (!halt_o && cyc < 400) begin
			@(posedge clock);
			#1;
			cyc++;
		end
		if (!halt_o) begin
			timeouts++;
			$display("timeout: halt never rose in scenario %0d", s);
		end
	endtask

	initial begin
		reset = 1'b1;
		redirect_i = 1'b0;
		redirect_pc_i = '0;
		arready_i = 1'b0;
		rvalid_i = 1'b0;
		r_i = '0;
		retire_ready_i = 1'b0;
		timeouts = 0;
		for (int s = 0; s < scen_rows; s++) begin
			apply_reset();
			if (scen[s].redirect_after != 0) begin
				wait_retires(int'(scen[s].redirect_after));
				if (timeouts != 0) begin
					break;
				end
				pulse_redirect(scen[s].target);
			end
			wait_halt(s);
			if (timeouts != 0) begin
				break;
			end
			// quiet time for the post-halt checks
			repeat (12) @(posedge clock);
			#1;
		end
		sva_errors = u_fetch_top.u_fetch_sva.fail_count;
		$display("errors: checker %0d, assertions %0d, timeouts %0d",
			chk_errors, sva_errors, timeouts);
		if (chk_errors == 0 && sva_errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/fetch_pkg.sv
hdl/fetch_unit.sv
hdl/fetch_queue.sv
hdl/inst_classifier.sv
hdl/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_sva.sv
bench/fetch_tb.sv
